// ==== source/noc_chain_pkg.sv ====
// Widths and node addresses shared by the chain and its testbench; addresses fit in 4 bits
package noc_chain_pkg;

	// Link word and 32-bit running sums
	localparam int noc_dw = 32;

	// Node address carried with every flit
	localparam int addr_w = 4;

	// Sink accumulator, wide enough never to wrap in practice
	localparam int sum_w = 64;

	// Burst length counter
	localparam int count_w = 8;

	// Node 1, the generator, has no eject path
	localparam logic [addr_w-1:0] node_gen = 4'd1;

	// Nodes with adapter and processor
	localparam logic [addr_w-1:0] node_two = 4'd2;
	localparam logic [addr_w-1:0] node_three = 4'd3;

	// End of chain, every flit that reaches it is absorbed
	localparam logic [addr_w-1:0] node_four = 4'd4;

endpackage

// ==== source/noc_link_if.sv ====
// Point-to-point flit link; sender holds data and dest while valid is high and ready is low
`timescale 1ns/1ns

interface noc_link_if;
	import noc_chain_pkg::*;

	// Payload word
	logic [noc_dw-1:0] data;
	// Destination node of this flit
	logic [addr_w-1:0] dest;
	// Handshake, transfer on a rising edge with both high
	logic valid;
	logic ready;

	// Upstream side
	modport sender (
		output data, dest, valid,
		input ready
	);

	// Downstream side
	modport receiver (
		input data, dest, valid,
		output ready
	);

endinterface

// ==== source/traffic_generator.sv ====
// Start is taken only while idle; a count of zero or a burst addressed to node 1 sends nothing
`timescale 1ns/1ns

module traffic_generator (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [noc_chain_pkg::noc_dw-1:0] first,
	input logic [noc_chain_pkg::count_w-1:0] count,
	input logic [noc_chain_pkg::addr_w-1:0] dest,
	noc_link_if.sender link
);
	import noc_chain_pkg::*;

	logic [noc_dw-1:0] word;
	logic [count_w-1:0] remaining;
	logic [addr_w-1:0] dest_q;
	logic busy;
	logic load;
	logic sent;

	// Busy while flits are still owed
	assign busy = (remaining != '0);
	// Node 1 cannot eject, so a burst to itself is dropped here
	assign load = start && !busy && (dest != node_gen);
	assign sent = link.valid && link.ready;

	// Burst length bookkeeping
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			remaining <= '0;
		end else if (load) begin
			remaining <= count;
		end else if (sent) begin
			remaining <= remaining - 1'b1;
		end
	end

	// Counting word and latched target
	always_ff @(posedge clk) begin
		if (load) begin
			word <= first;
			dest_q <= dest;
		end else if (sent) begin
			word <= word + 1'b1;
		end
	end

	assign link.data = word;
	assign link.dest = dest_q;
	assign link.valid = busy;

endmodule

// ==== source/noc_router_adapter.sv ====
// Forwarded flits have priority over injection; injected words always go to node_addr+1
`timescale 1ns/1ns

module noc_router_adapter #(
	parameter logic [noc_chain_pkg::addr_w-1:0] node_addr = noc_chain_pkg::node_two
) (
	input logic clk,
	input logic reset,
	noc_link_if.receiver link_in,
	noc_link_if.sender link_out,
	output logic [noc_chain_pkg::noc_dw-1:0] eject_data,
	output logic eject_valid,
	input logic eject_ready,
	input logic [noc_chain_pkg::noc_dw-1:0] inject_data,
	input logic inject_valid,
	output logic inject_ready
);
	import noc_chain_pkg::*;

	// Injected words are sent to the next node downstream
	localparam logic [addr_w-1:0] next_addr = node_addr + 1'b1;

	// One-flit eject buffer
	logic [noc_dw-1:0] ej_data;
	logic ej_full;
	// One-flit output register
	logic [noc_dw-1:0] out_data;
	logic [addr_w-1:0] out_dest;
	logic out_full;

	logic is_local;
	logic ej_free;
	logic out_free;
	logic ej_take;
	logic fwd_take;
	logic inj_take;

	// Route on the incoming dest field
	assign is_local = (link_in.dest == node_addr);

	// A slot is free when empty or drained on this edge
	assign ej_free = !ej_full || eject_ready;
	assign out_free = !out_full || link_out.ready;

	// Ready only toward the slot this flit targets
	assign link_in.ready = is_local ? ej_free : out_free;

	assign ej_take = link_in.valid && is_local && ej_free;
	assign fwd_take = link_in.valid && !is_local && out_free;

	// A waiting forward flit blocks injection, even while out is full
	assign inject_ready = out_free && !(link_in.valid && !is_local);
	assign inj_take = inject_valid && inject_ready;

	// Occupancy flags
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ej_full <= 1'b0;
			out_full <= 1'b0;
		end else begin
			ej_full <= ej_take || (ej_full && !eject_ready);
			out_full <= fwd_take || inj_take || (out_full && !link_out.ready);
		end
	end

	// Eject payload
	always_ff @(posedge clk) begin
		if (ej_take) begin
			ej_data <= link_in.data;
		end
	end

	// Output payload, forward first
	always_ff @(posedge clk) begin
		if (fwd_take) begin
			out_data <= link_in.data;
			out_dest <= link_in.dest;
		end else if (inj_take) begin
			out_data <= inject_data;
			out_dest <= next_addr;
		end
	end

	assign eject_data = ej_data;
	assign eject_valid = ej_full;

	assign link_out.data = out_data;
	assign link_out.dest = out_dest;
	assign link_out.valid = out_full;

endmodule

// ==== source/traffic_processor.sv ====
// Running sum wraps modulo 2^32; clear is expected only while no word is in flight
`timescale 1ns/1ns

module traffic_processor (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic [noc_chain_pkg::noc_dw-1:0] in_data,
	input logic in_valid,
	output logic in_ready,
	output logic [noc_chain_pkg::noc_dw-1:0] out_data,
	output logic out_valid,
	input logic out_ready
);
	import noc_chain_pkg::*;

	logic [noc_dw-1:0] sum;
	logic full;
	logic take;

	// Accept only when the result slot can be reused
	assign in_ready = !full || out_ready;
	assign take = in_valid && in_ready;

	// Accumulator, clear wins over a new word
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sum <= '0;
		end else if (clear) begin
			sum <= '0;
		end else if (take) begin
			sum <= sum + in_data;
		end
	end

	// Result valid until the adapter takes it
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			full <= 1'b0;
		end else begin
			full <= take || (full && !out_ready);
		end
	end

	// Each new sum is sent on
	assign out_data = sum;
	assign out_valid = full;

endmodule

// ==== source/traffic_sink.sv ====
// Always ready; every flit reaching the end of the chain is absorbed whatever its dest
`timescale 1ns/1ns

module traffic_sink (
	input logic clk,
	input logic reset,
	input logic clear,
	noc_link_if.receiver link,
	output logic [noc_chain_pkg::sum_w-1:0] data_out,
	output logic out_valid
);
	import noc_chain_pkg::*;

	logic [sum_w-1:0] sum;
	logic pulse;

	// Never back-pressures the chain
	assign link.ready = 1'b1;

	// Zero-extended accumulate, one pulse per flit
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sum <= '0;
			pulse <= 1'b0;
		end else begin
			pulse <= link.valid;
			if (clear) begin
				sum <= '0;
			end else if (link.valid) begin
				sum <= sum + sum_w'(link.data);
			end
		end
	end

	assign data_out = sum;
	assign out_valid = pulse;

endmodule

// ==== source/noc_chain_top.sv ====
// Dest must be node 2, 3 or 4; clear and start are honoured only while the chain is idle
`timescale 1ns/1ns

module noc_chain_top (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [noc_chain_pkg::noc_dw-1:0] first,
	input logic [noc_chain_pkg::count_w-1:0] count,
	input logic [noc_chain_pkg::addr_w-1:0] dest,
	input logic clear,
	output logic [noc_chain_pkg::sum_w-1:0] data_out,
	output logic out_valid
);
	import noc_chain_pkg::*;

	// Chain links
	noc_link_if link_a ();
	noc_link_if link_b ();
	noc_link_if link_c ();

	// Node 2 local ports
	logic [noc_dw-1:0] eject_data_2;
	logic eject_valid_2;
	logic eject_ready_2;
	logic [noc_dw-1:0] inject_data_2;
	logic inject_valid_2;
	logic inject_ready_2;

	// Node 3 local ports
	logic [noc_dw-1:0] eject_data_3;
	logic eject_valid_3;
	logic eject_ready_3;
	logic [noc_dw-1:0] inject_data_3;
	logic inject_valid_3;
	logic inject_ready_3;

	// Node 1
	traffic_generator gen (
		.clk(clk), .reset(reset), .start(start), .first(first),
		.count(count), .dest(dest), .link(link_a)
	);

	// Node 2
	noc_router_adapter #(.node_addr(node_two)) adapter_2 (
		.clk(clk), .reset(reset), .link_in(link_a), .link_out(link_b),
		.eject_data(eject_data_2), .eject_valid(eject_valid_2), .eject_ready(eject_ready_2),
		.inject_data(inject_data_2), .inject_valid(inject_valid_2),
		.inject_ready(inject_ready_2)
	);
	traffic_processor proc_2 (
		.clk(clk), .reset(reset), .clear(clear),
		.in_data(eject_data_2), .in_valid(eject_valid_2), .in_ready(eject_ready_2),
		.out_data(inject_data_2), .out_valid(inject_valid_2), .out_ready(inject_ready_2)
	);

	// Node 3
	noc_router_adapter #(.node_addr(node_three)) adapter_3 (
		.clk(clk), .reset(reset), .link_in(link_b), .link_out(link_c),
		.eject_data(eject_data_3), .eject_valid(eject_valid_3), .eject_ready(eject_ready_3),
		.inject_data(inject_data_3), .inject_valid(inject_valid_3),
		.inject_ready(inject_ready_3)
	);
	traffic_processor proc_3 (
		.clk(clk), .reset(reset), .clear(clear),
		.in_data(eject_data_3), .in_valid(eject_valid_3), .in_ready(eject_ready_3),
		.out_data(inject_data_3), .out_valid(inject_valid_3), .out_ready(inject_ready_3)
	);

	// Node 4
	traffic_sink sink (
		.clk(clk), .reset(reset), .clear(clear), .link(link_c),
		.data_out(data_out), .out_valid(out_valid)
	);

endmodule

// ==== bench/tb_noc_chain.sv ====
// Dest stays within nodes 2 to 4; the model keeps processor sums across bursts until a clear
`timescale 1ns/1ns

module tb_noc_chain;
	import noc_chain_pkg::*;

	// One table row, name packed as up to 12 characters
	typedef struct packed {
		logic [8*12-1:0] name;
		logic clear_first;
		logic [addr_w-1:0] dest;
		logic [noc_dw-1:0] first;
		logic [count_w-1:0] count;
		logic poke;
	} entry_t;

	localparam int n_entries = 13;
	// Idle cycles after the last pulse, to catch late extra pulses
	localparam int quiet_cycles = 12;

	logic clk = 1'b0;
	logic reset;
	logic start;
	logic [noc_dw-1:0] first;
	logic [count_w-1:0] count;
	logic [addr_w-1:0] dest;
	logic clear;
	logic [sum_w-1:0] data_out;
	logic out_valid;

	entry_t tests [n_entries];
	integer seed = 32'h20a5;
	int cycles = 0;
	int limit = 0;
	int pulses = 0;

	// Model state: both 32-bit processor sums and the 64-bit sink total
	logic [noc_dw-1:0] p2_sum;
	logic [noc_dw-1:0] p3_sum;
	logic [sum_w-1:0] total;

	noc_chain_top UUT (
		.clk(clk), .reset(reset), .start(start), .first(first), .count(count),
		.dest(dest), .clear(clear), .data_out(data_out), .out_valid(out_valid)
	);

	always #2 clk = ~clk;

	// Sink pulses seen so far
	always @(posedge clk) begin
		if (out_valid) begin
			pulses <= pulses + 1;
		end
	end

	// Run length guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout: the bursts did not complete within %0d cycles", limit);
			$display("** FAIL **");
			$fatal(1);
		end
	end

	task automatic check_value(input logic [8*12-1:0] test_name,
			input logic [63:0] expected, input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAIL %0s expected %0h actual %0h", test_name, expected, actual);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	function automatic entry_t make_entry(input logic [8*12-1:0] name, input logic clr,
			input logic [addr_w-1:0] d, input logic [noc_dw-1:0] f,
			input logic [count_w-1:0] n, input logic poke);
		entry_t e;
		e.name = name;
		e.clear_first = clr;
		e.dest = d;
		e.first = f;
		e.count = n;
		e.poke = poke;
		return e;
	endfunction

	// Rows, some first words random
	task automatic load_tests;
		tests[0] = make_entry("to_node4", 1'b0, node_four, 32'h10, 8'd8, 1'b0);
		tests[1] = make_entry("to_node3", 1'b0, node_three, 32'h100, 8'd6, 1'b0);
		tests[2] = make_entry("to_node2", 1'b0, node_two, 32'h7, 8'd5, 1'b0);
		tests[3] = make_entry("accum_n4", 1'b0, node_four, $random(seed), 8'd12, 1'b0);
		tests[4] = make_entry("clear_n3", 1'b1, node_three, $random(seed), 8'd9, 1'b0);
		tests[5] = make_entry("wrap_n2", 1'b0, node_two, 32'hffff_ff00, 8'd40, 1'b0);
		tests[6] = make_entry("wrap_n4", 1'b0, node_four, 32'hffff_fffc, 8'd8, 1'b0);
		tests[7] = make_entry("restart_n4", 1'b1, node_four, 32'h40, 8'd16, 1'b1);
		tests[8] = make_entry("restart_n2", 1'b0, node_two, $random(seed), 8'd20, 1'b1);
		tests[9] = make_entry("zero_len", 1'b0, node_three, 32'h5, 8'd0, 1'b0);
		tests[10] = make_entry("fwd_stall_n3", 1'b0, node_three, $random(seed), 8'd30, 1'b0);
		tests[11] = make_entry("clear_n2", 1'b1, node_two, $random(seed), 8'd25, 1'b0);
		tests[12] = make_entry("long_n3", 1'b0, node_three, 32'h8000_0000, 8'd60, 1'b1);
	endtask

	// Counting words, then one prefix-sum pass per processor on the way
	task automatic model_burst(input entry_t e);
		logic [noc_dw-1:0] word;
		int i;
		for (i = 0; i < e.count; i++) begin
			word = e.first + i;
			if (e.dest == node_four) begin
				total = total + {32'b0, word};
			end else if (e.dest == node_three) begin
				p3_sum = p3_sum + word;
				total = total + {32'b0, p3_sum};
			end else begin
				p2_sum = p2_sum + word;
				p3_sum = p3_sum + p2_sum;
				total = total + {32'b0, p3_sum};
			end
		end
	endtask

	task automatic run_entry(input entry_t e);
		int base;
		// Clear pulse while idle, model follows
		if (e.clear_first) begin
			@(posedge clk);
			clear <= 1'b1;
			@(posedge clk);
			clear <= 1'b0;
			@(posedge clk);
			p2_sum = '0;
			p3_sum = '0;
			total = '0;
			check_value(e.name, 64'd0, data_out);
		end
		base = pulses;
		@(posedge clk);
		start <= 1'b1;
		first <= e.first;
		count <= e.count;
		dest <= e.dest;
		@(posedge clk);
		start <= 1'b0;
		// Second start while the generator is still busy
		if (e.poke) begin
			repeat (2) @(posedge clk);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		model_burst(e);
		while (pulses - base < e.count) begin
			@(posedge clk);
		end
		repeat (quiet_cycles) @(posedge clk);
		check_value(e.name, 64'(e.count), 64'(pulses - base));
		check_value(e.name, total, data_out);
	endtask

	initial begin
		reset = 1'b1;
		start = 1'b0;
		first = '0;
		count = '0;
		dest = node_four;
		clear = 1'b0;
		p2_sum = '0;
		p3_sum = '0;
		total = '0;
		load_tests();
		// Budget grows with burst lengths
		for (int i = 0; i < n_entries; i++) begin
			limit = limit + (tests[i].count + 20) * 4;
		end
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		check_value("after_reset", 64'd0, {63'b0, out_valid});
		check_value("after_reset", 64'd0, data_out);
		for (int i = 0; i < n_entries; i++) begin
			run_entry(tests[i]);
		end
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== compile.f ====
source/noc_chain_pkg.sv
source/noc_link_if.sv
source/traffic_generator.sv
source/noc_router_adapter.sv
source/traffic_processor.sv
source/traffic_sink.sv
source/noc_chain_top.sv
bench/tb_noc_chain.sv

// ==== Bender.yml ====
package:
  name: noc_chain

sources:
  - source/noc_chain_pkg.sv
  - source/noc_link_if.sv
  - source/traffic_generator.sv
  - source/noc_router_adapter.sv
  - source/traffic_processor.sv
  - source/traffic_sink.sv
  - source/noc_chain_top.sv
  - target: simulation
    files:
      - bench/tb_noc_chain.sv
